// ==== project.f ====
verilog/cpu_pkg.sv
verilog/cpu_alu.sv
verilog/cpu_regfile.sv
verilog/cpu_control.sv
verilog/cpu_datapath.sv
verilog/cpu_top.sv
verif/cpu_tb_chk.sv
verif/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu

sources:
  - files:
      - verilog/cpu_pkg.sv
      - verilog/cpu_alu.sv
      - verilog/cpu_regfile.sv
      - verilog/cpu_control.sv
      - verilog/cpu_datapath.sv
      - verilog/cpu_top.sv
  - target: any(simulation, test)
    files:
      - verif/cpu_tb_chk.sv
      - verif/cpu_tb.sv

// ==== verif/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

  localparam int          MEM_WORDS    = 256;
  localparam int          HALT_TIMEOUT = 2000;
  localparam logic [15:0] SRC_ADR      = 16'h0100; // preloaded word for loads

  typedef enum logic [2:0] {T_ALU, T_BYTE, T_LOAD, T_BEQ, T_ILLEGAL, T_ALIGN} kind_e;

  typedef struct packed {
    kind_e       kind;
    opcode_e     op;    // alu op or load op
    opcode_e     st;    // store used by the program
    logic [15:0] a;
    logic [15:0] b;
    logic        rnd;   // random operands
    logic        slow;  // random wait states
    logic [1:0]  lane;
    logic [15:0] off;   // store target
  } row_t;

  logic              clk_i;
  logic              rst_i;
  logic              ack_i;
  logic [DATA_W-1:0] dat_i;
  logic [DATA_W-1:0] adr_o;
  logic [DATA_W-1:0] dat_o;
  logic              cyc_o;
  logic              we_o;
  logic [3:0]        sel_o;
  logic              halt_o;
  logic [3:0]        exception_o;

  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic [1:0]        wait_pool [256];
  logic [DATA_W-1:0] wr_adr[$];
  logic [DATA_W-1:0] wr_dat[$];
  logic [3:0]        wr_sel[$];
  logic [DATA_W-1:0] exp_adr[$];
  logic [DATA_W-1:0] exp_dat[$];
  logic [DATA_W-1:0] exp_mask[$];
  logic [3:0]        exp_sel[$];
  row_t              rows[$];
  string             names[$];
  logic [15:0]       ref_a [16];  // operands of the zero-wait alu runs
  logic [15:0]       ref_b [16];
  logic              slow_bus;
  logic              busy;
  int                waits_left;
  int                pool_idx;
  int                pc_w;
  int                errors;
  int                n_pass;
  int                n_fail;

  cpu_top i_cpu_top (.*);

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  task automatic respond();
    logic [7:0] w;
    w = adr_o[9:2];
    if (we_o) begin
      for (int i = 0; i < 4; i++) begin
        if (sel_o[i]) mem[w][8*i +: 8] = dat_o[8*i +: 8];
      end
      wr_adr.push_back(adr_o);
      wr_dat.push_back(dat_o);
      wr_sel.push_back(sel_o);
    end else begin
      dat_i = mem[w];
    end
    ack_i = 1'b1;
  endtask

  // memory model with one ack per request
  always @(posedge clk_i) begin
    #1;
    if (rst_i || ack_i) begin
      ack_i = 1'b0;
      dat_i = '0;
      busy  = 1'b0;
    end else if (cyc_o) begin
      if (!busy) begin
        busy       = 1'b1;
        waits_left = slow_bus ? int'(wait_pool[pool_idx % 256]) : 0;
        pool_idx++;
      end else begin
        waits_left--;
      end
      if (waits_left <= 0) respond();
    end
  end

  function automatic instr_t encode(input opcode_e op, input logic [3:0] ra,
                                    input logic [3:0] rb, input logic [3:0] rc,
                                    input logic [15:0] imm);
    instr_t i;
    i.op  = op;
    i.ra  = ra;
    i.rb  = rb;
    i.rc  = rc;
    i.imm = imm;
    return i;
  endfunction

  task automatic emit(input instr_t i);
    mem[pc_w] = i;
    pc_w++;
  endtask

  function automatic logic [DATA_W-1:0] alu_model(input opcode_e op,
                                                  input logic [DATA_W-1:0] x,
                                                  input logic [DATA_W-1:0] y);
    case (op)
      OP_ADD:  return x + y;
      OP_SUB:  return x - y;
      OP_AND:  return x & y;
      OP_OR:   return x | y;
      default: return x ^ y;
    endcase
  endfunction

  task automatic expect_write(input logic [15:0] adr, input logic [DATA_W-1:0] data,
                              input logic [3:0] sel, input logic [DATA_W-1:0] mask);
    exp_adr.push_back({16'h0, adr});
    exp_dat.push_back(data);
    exp_sel.push_back(sel);
    exp_mask.push_back(mask);
  endtask

  task automatic check_word(input string name, input logic [DATA_W-1:0] expected,
                            input logic [DATA_W-1:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_sel(input string name, input logic [3:0] expected,
                           input logic [3:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: sel expected %b, actual %b", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_exc(input string name, input logic [3:0] expected,
                           input logic [3:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: exception expected %0d, actual %0d", name, expected, actual);
      errors++;
    end
  endtask

  task automatic add_row(input string name, input kind_e kind, input opcode_e op,
                         input opcode_e st, input logic [15:0] a, input logic [15:0] b,
                         input logic rnd, input logic slow, input logic [1:0] lane,
                         input logic [15:0] off);
    row_t r;
    r.kind = kind;
    r.op   = op;
    r.st   = st;
    r.a    = a;
    r.b    = b;
    r.rnd  = rnd;
    r.slow = slow;
    r.lane = lane;
    r.off  = off;
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic build_table();
    add_row("add", T_ALU, OP_ADD, OP_STW, 16'h1234, 16'h4321, 0, 0, 0, 16'h0200);
    add_row("sub", T_ALU, OP_SUB, OP_STW, 16'h0005, 16'h0009, 0, 0, 0, 16'h0204);
    add_row("and_rnd", T_ALU, OP_AND, OP_STW, 16'h0, 16'h0, 1, 0, 0, 16'h0208);
    add_row("or_rnd", T_ALU, OP_OR, OP_STW, 16'h0, 16'h0, 1, 0, 0, 16'h020c);
    add_row("xor", T_ALU, OP_XOR, OP_STW, 16'hffff, 16'h0f0f, 0, 0, 0, 16'h0210);
    add_row("stb_lane0", T_BYTE, OP_LDI, OP_STB, 16'h015a, 16'h0, 0, 0, 0, 16'h0220);
    add_row("stb_lane1", T_BYTE, OP_LDI, OP_STB, 16'h02c3, 16'h0, 0, 0, 1, 16'h0220);
    add_row("stb_lane2", T_BYTE, OP_LDI, OP_STB, 16'h0381, 16'h0, 0, 0, 2, 16'h0220);
    add_row("stb_lane3", T_BYTE, OP_LDI, OP_STB, 16'h04e7, 16'h0, 0, 0, 3, 16'h0220);
    add_row("ldb_lane1", T_LOAD, OP_LDB, OP_STW, 16'hcafe, 16'hbeef, 0, 0, 1, 16'h0230);
    add_row("ldb_lane3", T_LOAD, OP_LDB, OP_STW, 16'hcafe, 16'hbeef, 0, 0, 3, 16'h0234);
    add_row("ldw", T_LOAD, OP_LDW, OP_STW, 16'h8765, 16'h4321, 0, 0, 0, 16'h0238);
    add_row("beq_taken", T_BEQ, OP_BEQ, OP_STW, 16'h0007, 16'h0007, 0, 0, 0, 16'h0240);
    add_row("beq_not_taken", T_BEQ, OP_BEQ, OP_STW, 16'h0007, 16'h0008, 0, 0, 0, 16'h0240);
    add_row("illegal_op", T_ILLEGAL, opcode_e'(4'hd), OP_STW, 16'h0, 16'h0, 0, 0, 0, 16'h0);
    add_row("stw_misaligned", T_ALIGN, OP_LDI, OP_STW, 16'h1234, 16'h0, 0, 0, 1, 16'h0260);
    add_row("add_slow", T_ALU, OP_ADD, OP_STW, 16'h0, 16'h0, 0, 1, 0, 16'h0200);
    add_row("sub_slow", T_ALU, OP_SUB, OP_STW, 16'h0, 16'h0, 0, 1, 0, 16'h0204);
    add_row("and_slow", T_ALU, OP_AND, OP_STW, 16'h0, 16'h0, 0, 1, 0, 16'h0208);
    add_row("or_slow", T_ALU, OP_OR, OP_STW, 16'h0, 16'h0, 0, 1, 0, 16'h020c);
    add_row("xor_slow", T_ALU, OP_XOR, OP_STW, 16'h0, 16'h0, 0, 1, 0, 16'h0210);
  endtask

  task automatic run_test(input int idx);
    row_t              r;
    string             name;
    logic [DATA_W-1:0] lw;
    logic [3:0]        exc;
    int                cycles;
    int                errs_before;
    r           = rows[idx];
    name        = names[idx];
    errs_before = errors;
    if (r.rnd) begin
      r.a = 16'($urandom);
      r.b = 16'($urandom);
    end
    if (r.kind == T_ALU) begin
      if (r.slow) begin
        r.a = ref_a[r.op];  // same operands as the zero-wait run
        r.b = ref_b[r.op];
      end else begin
        ref_a[r.op] = r.a;
        ref_b[r.op] = r.b;
      end
    end

    @(posedge clk_i);
    #1;
    rst_i    = 1'b1;
    slow_bus = r.slow;
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = {16'hf00d, 8'(i), ~8'(i)};
    wr_adr.delete();
    wr_dat.delete();
    wr_sel.delete();
    exp_adr.delete();
    exp_dat.delete();
    exp_sel.delete();
    exp_mask.delete();
    pc_w = 0;
    exc  = EXC_NONE;
    lw   = {r.a, r.b};

    case (r.kind)
      T_ALU: begin
        emit(encode(OP_LDI, 4'd1, 4'd0, 4'd0, r.a));
        emit(encode(OP_LDI, 4'd2, 4'd0, 4'd0, r.b));
        emit(encode(r.op, 4'd3, 4'd1, 4'd2, 16'h0));
        emit(encode(r.st, 4'd3, 4'd0, 4'd0, r.off));
        expect_write(r.off, alu_model(r.op, {16'h0, r.a}, {16'h0, r.b}), 4'hf, '1);
      end
      T_BYTE: begin
        emit(encode(OP_LDI, 4'd1, 4'd0, 4'd0, r.a));
        emit(encode(r.st, 4'd1, 4'd0, 4'd0, r.off + r.lane));
        expect_write(r.off + r.lane, 32'(r.a[7:0]) << (8 * r.lane),
                     4'b0001 << r.lane, 32'hff << (8 * r.lane));
      end
      T_LOAD: begin
        mem[SRC_ADR >> 2] = lw;
        emit(encode(r.op, 4'd1, 4'd0, 4'd0, SRC_ADR + r.lane));
        emit(encode(r.st, 4'd1, 4'd0, 4'd0, r.off));
        expect_write(r.off, (r.op == OP_LDB) ? (lw >> (8 * r.lane)) & 32'hff : lw, 4'hf, '1);
      end
      T_BEQ: begin
        emit(encode(OP_LDI, 4'd1, 4'd0, 4'd0, r.a));
        emit(encode(OP_LDI, 4'd2, 4'd0, 4'd0, r.b));
        emit(encode(OP_SUB, 4'd3, 4'd1, 4'd2, 16'h0));
        emit(encode(OP_BEQ, 4'd0, 4'd0, 4'd0, 16'd2)); // over the first marker
        emit(encode(OP_LDI, 4'd4, 4'd0, 4'd0, 16'h00aa));
        emit(encode(r.st, 4'd4, 4'd0, 4'd0, r.off));
        emit(encode(OP_LDI, 4'd5, 4'd0, 4'd0, 16'h00bb));
        emit(encode(r.st, 4'd5, 4'd0, 4'd0, r.off + 16'd4));
        if (r.a != r.b) expect_write(r.off, 32'haa, 4'hf, '1);
        expect_write(r.off + 16'd4, 32'hbb, 4'hf, '1);
      end
      T_ILLEGAL: begin
        emit(encode(r.op, 4'd0, 4'd0, 4'd0, 16'h0));
        exc = EXC_ILLEGAL;
      end
      default: begin
        emit(encode(OP_LDI, 4'd1, 4'd0, 4'd0, r.a));
        emit(encode(r.st, 4'd1, 4'd0, 4'd0, r.off + r.lane));
        exc = EXC_ALIGN;
      end
    endcase
    emit(encode(OP_HALT, 4'd0, 4'd0, 4'd0, 16'h0));

    repeat (10) @(posedge clk_i);
    #1;
    rst_i  = 1'b0;
    cycles = 0;
    while (!halt_o && cycles < HALT_TIMEOUT) begin
      @(posedge clk_i);
      #1;
      cycles++;
    end

    if (!halt_o) begin
      $display("%s: core did not halt within %0d cycles", name, HALT_TIMEOUT);
      errors++;
    end else begin
      check_exc(name, exc, exception_o);
      if (wr_adr.size() != exp_adr.size()) begin
        $display("%s: expected %0d bus writes but saw %0d", name, exp_adr.size(),
                 wr_adr.size());
        errors++;
      end else begin
        foreach (exp_adr[i]) begin
          check_word(name, exp_adr[i], wr_adr[i]);
          check_sel(name, exp_sel[i], wr_sel[i]);
          check_word(name, exp_dat[i], wr_dat[i] & exp_mask[i]);
        end
      end
    end
    if (errors == errs_before) begin
      n_pass++;
      $display("%s: ok", name);
    end else begin
      n_fail++;
      $display("%s: failed", name);
    end
  endtask

  initial begin
    rst_i    = 1'b1;
    ack_i    = 1'b0;
    dat_i    = '0;
    slow_bus = 1'b0;
    busy     = 1'b0;
    pool_idx = 0;
    errors   = 0;
    n_pass   = 0;
    n_fail   = 0;
    void'($urandom(32'h0a317947));
    for (int i = 0; i < 256; i++) wait_pool[i] = 2'($urandom % 4); // 0 to 3 wait states
    build_table();
    for (int i = 0; i < rows.size(); i++) run_test(i);
    $display("tests passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0 && i_cpu_top.i_cpu_tb_chk.fail_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/cpu_tb_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb_chk import cpu_pkg::*; (
  input logic              clk_i,
  input logic              rst_i,
  input logic              ack_i,
  input logic              cyc_o,
  input logic              we_o,
  input logic              halt_o,
  input logic [3:0]        sel_o,
  input logic [DATA_W-1:0] adr_o
);

  int fail_cnt = 0; // read by the testbench at the end of the run

  // request held until ack
  bus_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      cyc_o && !ack_i |=> $stable(adr_o) && $stable(we_o) && $stable(sel_o))
    else begin
      $error("bus request changed before ack");
      fail_cnt++;
    end

  write_in_cycle: assert property (@(posedge clk_i) disable iff (rst_i) we_o |-> cyc_o)
    else begin
      $error("we_o high outside a bus cycle");
      fail_cnt++;
    end

  lanes_active: assert property (@(posedge clk_i) disable iff (rst_i) cyc_o |-> sel_o != 4'b0000)
    else begin
      $error("bus cycle with no byte lane selected");
      fail_cnt++;
    end

  halt_sticky: assert property (@(posedge clk_i) disable iff (rst_i) halt_o |=> halt_o)
    else begin
      $error("halt_o dropped without reset");
      fail_cnt++;
    end

endmodule

bind cpu_top cpu_tb_chk i_cpu_tb_chk (.*);

`default_nettype wire

// ==== verilog/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              ack_i,
  input  logic [DATA_W-1:0] dat_i,
  output logic [DATA_W-1:0] adr_o,
  output logic [DATA_W-1:0] dat_o,
  output logic              cyc_o,
  output logic              we_o,
  output logic [3:0]        sel_o,
  output logic              halt_o,
  output logic [3:0]        exception_o
);

  ctrl_t  ctrl;
  instr_t ir;
  ccr_t   ccr;

  cpu_control i_cpu_control (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .ir_i        (ir),
    .ccr_i       (ccr),
    .adr_lo_i    (adr_o[1:0]),
    .ack_i       (ack_i),
    .ctrl_o      (ctrl),
    .cyc_o       (cyc_o),
    .we_o        (we_o),
    .sel_o       (sel_o),
    .halt_o      (halt_o),
    .exception_o (exception_o)
  );

  cpu_datapath i_cpu_datapath (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .ctrl_i (ctrl),
    .sel_i  (sel_o),
    .we_i   (we_o),
    .dat_i  (dat_i),
    .ir_o   (ir),
    .ccr_o  (ccr),
    .adr_o  (adr_o),
    .dat_o  (dat_o)
  );

endmodule

`default_nettype wire

// ==== verilog/cpu_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_datapath import cpu_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  input  ctrl_t             ctrl_i,
  input  logic [3:0]        sel_i,
  input  logic              we_i,
  input  logic [DATA_W-1:0] dat_i,
  output instr_t            ir_o,
  output ccr_t              ccr_o,
  output logic [DATA_W-1:0] adr_o,
  output logic [DATA_W-1:0] dat_o
);

  logic [DATA_W-1:0] pc;
  logic [DATA_W-1:0] mar;
  logic [DATA_W-1:0] mdr;
  logic [DATA_W-1:0] a;
  logic [DATA_W-1:0] b;
  logic [DATA_W-1:0] pc_next;
  logic [DATA_W-1:0] mar_next;
  logic [DATA_W-1:0] mdr_next;
  logic [DATA_W-1:0] sval;
  logic [DATA_W-1:0] uval;
  logic [DATA_W-1:0] alu_in2;
  logic [DATA_W-1:0] alu_out;
  logic [DATA_W-1:0] reg_in;
  logic [DATA_W-1:0] rf_out1;
  logic [DATA_W-1:0] rf_out2;
  logic [DATA_W-1:0] bus_rd;
  logic [DATA_W-1:0] bus_wr;
  logic [DATA_W-1:0] lane_mask;
  instr_t            ir;
  ccr_t              ccr;
  ccr_t              alu_flags;

  assign sval = {{(DATA_W-16){ir.imm[15]}}, ir.imm};
  assign uval = {{(DATA_W-16){1'b0}}, ir.imm};

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      pc  <= RESET_PC;
      ir  <= '0;
      ccr <= '0;
    end else begin
      pc <= pc_next;
      if (ctrl_i.ir_write) begin
        ir <= instr_t'(dat_i);
      end
      if (ctrl_i.ccr_write) begin
        ccr <= alu_flags;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    mar <= mar_next;
    mdr <= mdr_next;
    if (ctrl_i.a_write) begin
      a <= rf_out1;
    end
    if (ctrl_i.b_write) begin
      b <= rf_out2;
    end
  end

  always_comb begin
    case (ctrl_i.pc_sel)
      PC_NEXT: pc_next = pc + DATA_W'(4);
      PC_REL:  pc_next = pc + {sval[DATA_W-3:0], 2'b00}; // pc already +4
      PC_ALU:  pc_next = alu_out;
      default: pc_next = pc;
    endcase
    mar_next = (ctrl_i.mar_sel == MAR_ALU) ? alu_out : mar;
    case (ctrl_i.mdr_sel)
      MDR_BUS: mdr_next = bus_rd;
      MDR_A:   mdr_next = a;
      default: mdr_next = mdr;
    endcase
    case (ctrl_i.reg_sel)
      REG_MDR:  reg_in = mdr;
      REG_UVAL: reg_in = uval;
      default:  reg_in = alu_out;
    endcase
    alu_in2 = (ctrl_i.alu2_sel == ALU2_SVAL) ? sval : b;
  end

  // byte loads come back right aligned
  always_comb begin
    case (sel_i)
      4'b0001: bus_rd = {24'h0, dat_i[7:0]};
      4'b0010: bus_rd = {24'h0, dat_i[15:8]};
      4'b0100: bus_rd = {24'h0, dat_i[23:16]};
      4'b1000: bus_rd = {24'h0, dat_i[31:24]};
      default: bus_rd = dat_i;
    endcase
  end

  assign lane_mask = {{8{sel_i[3]}}, {8{sel_i[2]}}, {8{sel_i[1]}}, {8{sel_i[0]}}};
  assign bus_wr    = (sel_i == 4'b1111) ? mdr : ({4{mdr[7:0]}} & lane_mask);
  assign dat_o     = we_i ? bus_wr : '0;
  assign adr_o     = ctrl_i.addr_sel ? mar : pc;
  assign ir_o      = ir;
  assign ccr_o     = ccr;

  cpu_alu i_cpu_alu (
    .in1_i   (a),
    .in2_i   (alu_in2),
    .func_i  (ctrl_i.alu_func),
    .out_o   (alu_out),
    .flags_o (alu_flags)
  );

  cpu_regfile i_cpu_regfile (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .rd1_i   (ctrl_i.rd1),
    .rd2_i   (ctrl_i.rd2),
    .wr_i    (ctrl_i.wr),
    .we_i    (ctrl_i.reg_write),
    .data_i  (reg_in),
    .data1_o (rf_out1),
    .data2_o (rf_out2)
  );

endmodule

`default_nettype wire

// ==== verilog/cpu_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_control import cpu_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  instr_t     ir_i,
  input  ccr_t       ccr_i,
  input  logic [1:0] adr_lo_i,
  input  logic       ack_i,
  output ctrl_t      ctrl_o,
  output logic       cyc_o,
  output logic       we_o,
  output logic [3:0] sel_o,
  output logic       halt_o,
  output logic [3:0] exception_o
);

  typedef enum logic [2:0] {
    FETCH,
    DECODE,
    EXEC,
    ADDR,
    MEM,
    WB,
    HALTED
  } state_e;

  state_e     state;
  state_e     state_next;
  logic [3:0] exc_next;
  logic       is_load;
  logic       is_store;
  logic       is_byte;
  logic       bus_done;

  assign is_load  = (ir_i.op == OP_LDW) || (ir_i.op == OP_LDB);
  assign is_store = (ir_i.op == OP_STW) || (ir_i.op == OP_STB);
  assign is_byte  = (ir_i.op == OP_LDB) || (ir_i.op == OP_STB);
  assign bus_done = cyc_o && ack_i;

  function automatic alu_func_e alu_op(input opcode_e op);
    case (op)
      OP_SUB:  return ALU_SUB;
      OP_AND:  return ALU_AND;
      OP_OR:   return ALU_OR;
      OP_XOR:  return ALU_XOR;
      OP_JMP:  return ALU_PASSB;
      default: return ALU_ADD;  // add and address calc
    endcase
  endfunction

  always_comb begin
    ctrl_o          = '0; // hold everything
    ctrl_o.alu_func = alu_op(ir_i.op);
    ctrl_o.rd1      = ir_i.rb;
    ctrl_o.rd2      = (ir_i.op == OP_JMP) ? ir_i.rb : ir_i.rc;
    ctrl_o.wr       = ir_i.ra;
    state_next      = state;
    exc_next        = exception_o;
    case (state)
      FETCH: begin
        if (bus_done) begin
          ctrl_o.ir_write = 1'b1;
          ctrl_o.pc_sel   = PC_NEXT;
          state_next      = DECODE;
        end
      end
      DECODE: begin
        ctrl_o.a_write = 1'b1;
        ctrl_o.b_write = 1'b1;
        case (ir_i.op)
          OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LDI,
          OP_LDW, OP_LDB, OP_STW, OP_STB, OP_BEQ, OP_JMP: state_next = EXEC;
          OP_HALT: begin
            state_next = HALTED;
            exc_next   = EXC_NONE;
          end
          default: begin
            state_next = HALTED;
            exc_next   = EXC_ILLEGAL;
          end
        endcase
      end
      EXEC: begin
        state_next = FETCH;
        case (ir_i.op)
          OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
            ctrl_o.reg_write = 1'b1;
            ctrl_o.ccr_write = 1'b1;
          end
          OP_LDI: begin
            ctrl_o.reg_sel   = REG_UVAL;
            ctrl_o.reg_write = 1'b1;
          end
          OP_BEQ: begin
            if (ccr_i.zero) begin
              ctrl_o.pc_sel = PC_REL;
            end
          end
          OP_JMP: ctrl_o.pc_sel = PC_ALU;
          default: begin
            // loads and stores, mar gets rb + imm
            ctrl_o.alu2_sel = ALU2_SVAL;
            ctrl_o.mar_sel  = MAR_ALU;
            state_next      = ADDR;
            if (is_store) begin
              ctrl_o.rd1     = ir_i.ra;  // store data replaces base in a
              ctrl_o.a_write = 1'b1;
            end
          end
        endcase
      end
      ADDR: begin
        ctrl_o.addr_sel = 1'b1;
        if (is_store) begin
          ctrl_o.mdr_sel = MDR_A;
        end
        if (!is_byte && (adr_lo_i != 2'b00)) begin
          state_next = HALTED;
          exc_next   = EXC_ALIGN;
        end else begin
          state_next = MEM;
        end
      end
      MEM: begin
        ctrl_o.addr_sel = 1'b1;
        if (bus_done) begin
          if (is_load) begin
            ctrl_o.mdr_sel = MDR_BUS;
            state_next     = WB;
          end else begin
            state_next = FETCH;
          end
        end
      end
      WB: begin
        ctrl_o.reg_sel   = REG_MDR;
        ctrl_o.reg_write = 1'b1;
        state_next       = FETCH;
      end
      default: state_next = HALTED;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state       <= FETCH;
      cyc_o       <= 1'b0;
      exception_o <= EXC_NONE;
    end else begin
      state       <= state_next;
      // completing access always leaves one idle cycle
      cyc_o       <= ((state_next == FETCH) || (state_next == MEM)) && !bus_done;
      exception_o <= exc_next;
    end
  end

  assign we_o   = cyc_o && (state == MEM) && is_store;
  assign sel_o  = ((state == MEM) && is_byte) ? (4'b0001 << adr_lo_i) : 4'b1111;
  assign halt_o = (state == HALTED);  // terminal until reset

endmodule

`default_nettype wire

// ==== verilog/cpu_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile import cpu_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic [3:0]        rd1_i,
  input  logic [3:0]        rd2_i,
  input  logic [3:0]        wr_i,
  input  logic              we_i,
  input  logic [DATA_W-1:0] data_i,
  output logic [DATA_W-1:0] data1_o,
  output logic [DATA_W-1:0] data2_o
);

  logic [DATA_W-1:0] regs [NREGS];

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (wr_i != 4'd0)) begin
      regs[wr_i] <= data_i;
    end
  end

  // r0 is hardwired zero
  assign data1_o = (rd1_i == 4'd0) ? '0 : regs[rd1_i];
  assign data2_o = (rd2_i == 4'd0) ? '0 : regs[rd2_i];

endmodule

`default_nettype wire

// ==== verilog/cpu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_alu import cpu_pkg::*; (
  input  logic [DATA_W-1:0] in1_i,
  input  logic [DATA_W-1:0] in2_i,
  input  alu_func_e         func_i,
  output logic [DATA_W-1:0] out_o,
  output ccr_t              flags_o
);

  logic [DATA_W:0] sum;   // msb is carry or borrow
  logic            ovf;
  logic            s1;
  logic            s2;

  assign s1 = in1_i[DATA_W-1];
  assign s2 = in2_i[DATA_W-1];

  always_comb begin
    sum = '0;
    ovf = 1'b0;
    case (func_i)
      ALU_ADD: begin
        sum = {1'b0, in1_i} + {1'b0, in2_i};
        ovf = (s1 == s2) && (sum[DATA_W-1] != s1);
      end
      ALU_SUB: begin
        sum = {1'b0, in1_i} - {1'b0, in2_i};
        ovf = (s1 != s2) && (sum[DATA_W-1] != s1);
      end
      ALU_AND:   sum = {1'b0, in1_i & in2_i};
      ALU_OR:    sum = {1'b0, in1_i | in2_i};
      ALU_XOR:   sum = {1'b0, in1_i ^ in2_i};
      ALU_PASSB: sum = {1'b0, in2_i}; // jmp target
      default:   sum = '0;
    endcase
  end

  assign out_o = sum[DATA_W-1:0];

  assign flags_o.carry = sum[DATA_W];
  assign flags_o.less  = sum[DATA_W-1] ^ ovf;  // negative xor overflow
  assign flags_o.zero  = (out_o == '0);

endmodule

`default_nettype wire

// ==== verilog/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  localparam int DATA_W = 32;
  localparam int NREGS  = 16;

  localparam logic [DATA_W-1:0] RESET_PC = '0;

  // exception codes, latched on the way into halt
  localparam logic [3:0] EXC_NONE    = 4'd0;
  localparam logic [3:0] EXC_ILLEGAL = 4'd1;
  localparam logic [3:0] EXC_ALIGN   = 4'd2;

  typedef enum logic [3:0] {
    OP_ADD  = 4'h0,
    OP_SUB  = 4'h1,
    OP_AND  = 4'h2,
    OP_OR   = 4'h3,
    OP_XOR  = 4'h4,
    OP_LDI  = 4'h5,
    OP_LDW  = 4'h6,
    OP_LDB  = 4'h7,
    OP_STW  = 4'h8,
    OP_STB  = 4'h9,
    OP_BEQ  = 4'ha,
    OP_JMP  = 4'hb,
    OP_HALT = 4'hc
  } opcode_e; // d..f illegal

  typedef struct packed {
    opcode_e     op;
    logic [3:0]  ra;  // dest, or store source
    logic [3:0]  rb;
    logic [3:0]  rc;
    logic [15:0] imm;
  } instr_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASSB
  } alu_func_e;

  typedef enum logic [1:0] {PC_PC, PC_NEXT, PC_REL, PC_ALU} pc_sel_e;
  typedef enum logic [1:0] {MAR_MAR, MAR_ALU} mar_sel_e;
  typedef enum logic [1:0] {MDR_MDR, MDR_BUS, MDR_A} mdr_sel_e;
  typedef enum logic [1:0] {REG_ALU, REG_MDR, REG_UVAL} reg_sel_e;
  typedef enum logic [1:0] {ALU2_B, ALU2_SVAL} alu2_sel_e;

  typedef struct packed {
    logic carry;
    logic less;   // signed compare result
    logic zero;
  } ccr_t;

  // one word of control per cycle, sequencer to datapath
  typedef struct packed {
    pc_sel_e    pc_sel;
    mar_sel_e   mar_sel;
    mdr_sel_e   mdr_sel;
    reg_sel_e   reg_sel;
    alu2_sel_e  alu2_sel;
    alu_func_e  alu_func;
    logic       ir_write;
    logic       a_write;
    logic       b_write;
    logic       ccr_write;
    logic       reg_write;
    logic       addr_sel;   // 0 pc, 1 mar
    logic [3:0] rd1;
    logic [3:0] rd2;
    logic [3:0] wr;
  } ctrl_t;

endpackage

`default_nettype wire
